/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module dma_target_tb -Mdir obj_dir
	./obj_dir/Vdma_target_tb

clean:
	rm -rf obj_dir

/* design/dma_ahb_writer.sv */
`timescale 1ns/1ns
`include "dma_settings.svh"

module dma_ahb_writer
  import dma_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  input  addr_t       start_addr,
  input  word_t       data,
  input  logic        valid,
  output logic        ready,
  output logic        done,
  output logic [1:0]  htrans,
  output addr_t       haddr,
  output word_t       hwdata,
  input  logic        hready
);

  writer_state_t state;
  addr_t         addr_q;
  logic          first_q;
  logic          accept;

  ////////////////////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////////////////////

  // New beat allowed unless the previous data phase is stalled
  assign ready  = (state == WR_IDLE) || hready;
  assign accept = valid && ready;

  // Accepted word goes on the bus in the same cycle
  assign htrans = !accept ? `DMA_HTRANS_IDLE :
                  first_q ? `DMA_HTRANS_NONSEQ : `DMA_HTRANS_SEQ;
  assign haddr  = addr_q;

  // Data phase finishes when the slave is ready
  assign done = (state == WR_DATA_PHASE) && hready;

  ////////////////////////////////////////////////////////////////////////////
  // Running address and burst position
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q  <= '0;
      first_q <= 1'b0;
    end else if (start) begin
      addr_q  <= start_addr;
      first_q <= 1'b1;
    end else if (accept) begin
      // Word-sized beats
      addr_q  <= addr_q + addr_t'(4);
      first_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////////////////////////////////////////

  // Write data follows its address by one cycle, held through wait states
  always_ff @(posedge clk) begin
    if (accept) begin
      hwdata <= data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= WR_IDLE;
    end else begin
      case (state)
        WR_IDLE: begin
          if (accept) begin
            state <= WR_DATA_PHASE;
          end
        end
        WR_DATA_PHASE: begin
          // Back to back beats keep the pipeline full
          if (hready && !accept) begin
            state <= WR_IDLE;
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

endmodule

/* design/dma_l2r_ctrl.sv */
`timescale 1ns/1ns
`include "dma_settings.svh"

module dma_l2r_ctrl
  import dma_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  flit_t buf_flit,
  input  logic  buf_valid,
  output logic  buf_ready,
  input  logic  buf_last,
  output logic  wr_start,
  output addr_t wr_addr,
  output word_t wr_data,
  output logic  wr_valid,
  input  logic  wr_ready,
  input  logic  wr_done,
  output flit_t noc_out_flit,
  output logic  noc_out_valid,
  input  logic  noc_out_ready
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  tile_t       src_tile;
  packet_id_t  pkt_id;
  logic        req_last;
  logic        all_sent;
  logic [1:0]  pending;
  logic        handoff;
  logic [1:0]  ptype;

  // Header fields and payload slice of the current flit
  assign ptype   = buf_flit[`DMA_PACKET_TYPE_MSB:`DMA_PACKET_TYPE_LSB];
  assign wr_addr = buf_flit[`DMA_WORD_WIDTH-1:0];
  assign wr_data = buf_flit[`DMA_WORD_WIDTH-1:0];
  assign handoff = wr_valid && wr_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Next state and handshakes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next    = state;
    buf_ready     = 1'b0;
    wr_start      = 1'b0;
    wr_valid      = 1'b0;
    noc_out_valid = 1'b0;
    case (state)
      CTRL_IDLE: begin
        buf_ready = 1'b1;
        if (buf_valid) begin
          if (ptype == `DMA_PTYPE_L2R_REQ) begin
            state_next = CTRL_GET_ADDR;
          end else if (!buf_last) begin
            // Anything else is thrown away up to its last flit
            state_next = CTRL_DRAIN;
          end
        end
      end
      CTRL_GET_ADDR: begin
        buf_ready = 1'b1;
        if (buf_valid) begin
          wr_start = 1'b1;
          // No payload at all, nothing to wait for
          if (buf_last) begin
            state_next = req_last ? CTRL_SEND_RESP : CTRL_IDLE;
          end else begin
            state_next = CTRL_WRITE_DATA;
          end
        end
      end
      CTRL_WRITE_DATA: begin
        // Stop feeding once the closing flit is handed over
        wr_valid  = buf_valid && !all_sent;
        buf_ready = wr_ready && !all_sent;
        if (all_sent && wr_done && (pending == 2'd1)) begin
          state_next = req_last ? CTRL_SEND_RESP : CTRL_IDLE;
        end
      end
      CTRL_DRAIN: begin
        buf_ready = 1'b1;
        if (buf_valid && buf_last) begin
          state_next = CTRL_IDLE;
        end
      end
      CTRL_SEND_RESP: begin
        noc_out_valid = 1'b1;
        if (noc_out_ready) begin
          state_next = CTRL_IDLE;
        end
      end
      default: state_next = CTRL_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response flit
  ////////////////////////////////////////////////////////////////////////////

  // Built from registered header fields, so it holds while waiting
  always_comb begin
    noc_out_flit = '0;
    noc_out_flit[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB]     = `DMA_FLIT_SINGLE;
    noc_out_flit[`DMA_DEST_MSB:`DMA_DEST_LSB]               = src_tile;
    noc_out_flit[`DMA_CLASS_MSB:`DMA_CLASS_LSB]             = `DMA_CLASS_DMA;
    noc_out_flit[`DMA_PACKET_ID_MSB:`DMA_PACKET_ID_LSB]     = pkt_id;
    noc_out_flit[`DMA_PACKET_TYPE_MSB:`DMA_PACKET_TYPE_LSB] = `DMA_PTYPE_L2R_RESP;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  // Header capture, taken when the header is popped
  always_ff @(posedge clk) begin
    if ((state == CTRL_IDLE) && buf_valid) begin
      src_tile <= buf_flit[`DMA_SOURCE_MSB:`DMA_SOURCE_LSB];
      pkt_id   <= buf_flit[`DMA_PACKET_ID_MSB:`DMA_PACKET_ID_LSB];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= CTRL_IDLE;
      req_last <= 1'b0;
      all_sent <= 1'b0;
      pending  <= '0;
    end else begin
      state <= state_next;
      if ((state == CTRL_IDLE) && buf_valid) begin
        req_last <= buf_flit[`DMA_REQ_LAST];
      end

      // Words handed to the writer but not yet written
      pending <= pending + {1'b0, handoff} - {1'b0, wr_done};

      if (state != CTRL_WRITE_DATA) begin
        all_sent <= 1'b0;
      end else if (handoff && buf_last) begin
        all_sent <= 1'b1;
      end
    end
  end

endmodule

/* design/dma_packet_buffer.sv */
`timescale 1ns/1ns
`include "dma_settings.svh"

module dma_packet_buffer
  import dma_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  flit_t in_flit,
  input  logic  in_valid,
  output logic  in_ready,
  output flit_t out_flit,
  output logic  out_valid,
  input  logic  out_ready,
  output logic  out_last
);

  ////////////////////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  flit_t    mem [`DMA_BUF_DEPTH];
  buf_ptr_t wr_ptr;
  buf_ptr_t rd_ptr;
  count_t   fill;
  count_t   pkt_count;
  logic     push;
  logic     pop;
  logic     in_last;

  // Last or single flit closes a packet
  function automatic logic is_last(input flit_t flit);
    logic [1:0] ftype;
    ftype = flit[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB];
    return (ftype == `DMA_FLIT_LAST) || (ftype == `DMA_FLIT_SINGLE);
  endfunction

  // Backpressure only when every entry is taken
  assign in_ready = (fill != count_t'(`DMA_BUF_DEPTH));
  assign push     = in_valid && in_ready;

  // Present only whole packets downstream
  assign out_valid = (pkt_count != '0);
  assign pop       = out_valid && out_ready;
  assign out_flit  = mem[rd_ptr];
  assign out_last  = is_last(out_flit);
  assign in_last   = is_last(in_flit);

  ////////////////////////////////////////////////////////////////////////////
  // Flit memory
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers, fill level and packet count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill      <= '0;
      pkt_count <= '0;
    end else begin
      // Pointers wrap at the buffer depth
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      if (push && !pop) begin
        fill <= fill + 1'b1;
      end else if (pop && !push) begin
        fill <= fill - 1'b1;
      end

      // Complete packets stored, closing flit in vs closing flit out
      if ((push && in_last) && !(pop && out_last)) begin
        pkt_count <= pkt_count + 1'b1;
      end else if ((pop && out_last) && !(push && in_last)) begin
        pkt_count <= pkt_count - 1'b1;
      end
    end
  end

endmodule

/* design/dma_pkg.sv */
`include "dma_settings.svh"

package dma_pkg;

  // Whole NoC flit, type bits on top
  typedef logic [`DMA_FLIT_WIDTH-1:0] flit_t;

  // Bus data word, also the payload part of a flit
  typedef logic [`DMA_WORD_WIDTH-1:0] word_t;

  // Byte address on the AHB side
  typedef logic [31:0] addr_t;

  // Tile number, same width as DEST and SOURCE
  typedef logic [`DMA_SOURCE_MSB-`DMA_SOURCE_LSB:0] tile_t;

  // Request tag, echoed back in the response
  typedef logic [`DMA_PACKET_ID_MSB-`DMA_PACKET_ID_LSB:0] packet_id_t;

  // Buffer index and occupancy (one extra bit for full)
  typedef logic [$clog2(`DMA_BUF_DEPTH)-1:0] buf_ptr_t;
  typedef logic [$clog2(`DMA_BUF_DEPTH):0]   count_t;

  // Request parser states
  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_GET_ADDR,
    CTRL_WRITE_DATA,
    CTRL_DRAIN,
    CTRL_SEND_RESP
  } ctrl_state_t;

  // AHB writer states
  typedef enum logic {
    WR_IDLE,
    WR_DATA_PHASE
  } writer_state_t;

endpackage

/* design/dma_settings.svh */
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// Flit and bus word widths
`define DMA_FLIT_WIDTH 34
`define DMA_WORD_WIDTH 32

// Input buffer entries, one full packet fits
`define DMA_BUF_DEPTH 16

// Header field positions
`define DMA_FLIT_TYPE_MSB   33
`define DMA_FLIT_TYPE_LSB   32
`define DMA_DEST_MSB        31
`define DMA_DEST_LSB        27
`define DMA_CLASS_MSB       26
`define DMA_CLASS_LSB       24
`define DMA_PACKET_ID_MSB   23
`define DMA_PACKET_ID_LSB   20
`define DMA_PACKET_TYPE_MSB 19
`define DMA_PACKET_TYPE_LSB 18
`define DMA_SOURCE_MSB      17
`define DMA_SOURCE_LSB      13
`define DMA_REQ_LAST        12

// Flit type codes
`define DMA_FLIT_PAYLOAD 2'b00
`define DMA_FLIT_HEADER  2'b01
`define DMA_FLIT_LAST    2'b10
`define DMA_FLIT_SINGLE  2'b11

// Packet class and packet type codes
`define DMA_CLASS_DMA          3'b010
`define DMA_PTYPE_L2R_REQ      2'b00
`define DMA_PTYPE_R2L_REQ      2'b01
`define DMA_PTYPE_L2R_RESP     2'b10

// AHB-Lite transfer types
`define DMA_HTRANS_IDLE   2'b00
`define DMA_HTRANS_NONSEQ 2'b10
`define DMA_HTRANS_SEQ    2'b11

`endif

/* design/dma_target.sv */
`timescale 1ns/1ns

module dma_target
  import dma_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  flit_t      noc_in_flit,
  input  logic       noc_in_valid,
  output logic       noc_in_ready,
  output flit_t      noc_out_flit,
  output logic       noc_out_valid,
  input  logic       noc_out_ready,
  output logic [1:0] htrans,
  output addr_t      haddr,
  output word_t      hwdata,
  input  logic       hready
);

  // Buffer to controller
  flit_t buf_flit;
  logic  buf_valid;
  logic  buf_ready;
  logic  buf_last;

  // Controller to writer
  addr_t wr_addr;
  logic  wr_start;
  word_t wr_data;
  logic  wr_valid;
  logic  wr_ready;
  logic  wr_done;

  ////////////////////////////////////////////////////////////////////////////
  // Whole packets only reach the controller
  ////////////////////////////////////////////////////////////////////////////

  dma_packet_buffer u_packet_buffer (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (noc_in_flit),
    .in_valid  (noc_in_valid),
    .in_ready  (noc_in_ready),
    .out_flit  (buf_flit),
    .out_valid (buf_valid),
    .out_ready (buf_ready),
    .out_last  (buf_last)
  );

  dma_l2r_ctrl u_l2r_ctrl (
    .clk           (clk),
    .rst           (rst),
    .buf_flit      (buf_flit),
    .buf_valid     (buf_valid),
    .buf_ready     (buf_ready),
    .buf_last      (buf_last),
    .wr_start      (wr_start),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_valid      (wr_valid),
    .wr_ready      (wr_ready),
    .wr_done       (wr_done),
    .noc_out_flit  (noc_out_flit),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready)
  );

  // Write-only AHB master
  dma_ahb_writer u_ahb_writer (
    .clk        (clk),
    .rst        (rst),
    .start      (wr_start),
    .start_addr (wr_addr),
    .data       (wr_data),
    .valid      (wr_valid),
    .ready      (wr_ready),
    .done       (wr_done),
    .htrans     (htrans),
    .haddr      (haddr),
    .hwdata     (hwdata),
    .hready     (hready)
  );

endmodule

/* sim.f */
+incdir+design
design/dma_pkg.sv
design/dma_packet_buffer.sv
design/dma_ahb_writer.sv
design/dma_l2r_ctrl.sv
design/dma_target.sv
tests/dma_target_tb.sv

/* tests/dma_target_tb.sv */
`timescale 1ns/1ns
`include "dma_settings.svh"

module dma_target_tb
  import dma_pkg::*;
();

  localparam int    HALF_PERIOD    = 4;
  localparam int    NUM_ROWS       = 10;
  localparam int    CYCLES_PER_WORD = 40;
  localparam int    WATCH_MARGIN   = 2000;
  localparam tile_t TARGET_TILE    = 5'd6;

  // Packet, bus stall pattern and response backpressure for one run
  typedef struct packed {
    logic [1:0]  ptype;
    tile_t       src;
    packet_id_t  id;
    logic        req_last;
    addr_t       addr;
    logic [4:0]  words;
    logic [15:0] stall_mask;
    logic [3:0]  resp_stall;
    logic        exp_resp;
  } test_row_t;

  // One AHB write the slave model should see
  typedef struct packed {
    addr_t      addr;
    word_t      data;
    logic [1:0] trans;
  } bus_write_t;

  logic       clk;
  logic       rst;
  flit_t      noc_in_flit;
  logic       noc_in_valid;
  logic       noc_in_ready;
  flit_t      noc_out_flit;
  logic       noc_out_valid;
  logic       noc_out_ready;
  logic [1:0] htrans;
  addr_t      haddr;
  word_t      hwdata;
  logic       hready;

  test_row_t   rows [NUM_ROWS];
  bus_write_t  exp_writes [$];
  flit_t       exp_resps [$];
  logic [31:0] lfsr_state;
  logic [15:0] hready_mask;
  logic [3:0]  resp_stall;

  dma_target u_dma_target (
    .clk           (clk),
    .rst           (rst),
    .noc_in_flit   (noc_in_flit),
    .noc_in_valid  (noc_in_valid),
    .noc_in_ready  (noc_in_ready),
    .noc_out_flit  (noc_out_flit),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready),
    .htrans        (htrans),
    .haddr         (haddr),
    .hwdata        (hwdata),
    .hready        (hready)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Error handling and checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] %0t ns %s: got %h, expected %h",
                          $time, name, actual, expected));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Payload source and flit builders
  ////////////////////////////////////////////////////////////////////////////

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // One LFSR step per payload bit
  task automatic draw_word(output word_t w);
    int i;
    w = '0;
    for (i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic flit_t make_header(input test_row_t row);
    flit_t f;
    f = '0;
    f[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB]     = `DMA_FLIT_HEADER;
    f[`DMA_DEST_MSB:`DMA_DEST_LSB]               = TARGET_TILE;
    f[`DMA_CLASS_MSB:`DMA_CLASS_LSB]             = `DMA_CLASS_DMA;
    f[`DMA_PACKET_ID_MSB:`DMA_PACKET_ID_LSB]     = row.id;
    f[`DMA_PACKET_TYPE_MSB:`DMA_PACKET_TYPE_LSB] = row.ptype;
    f[`DMA_SOURCE_MSB:`DMA_SOURCE_LSB]           = row.src;
    f[`DMA_REQ_LAST]                             = row.req_last;
    return f;
  endfunction

  // Response goes back to the requesting tile with all other bits zero
  function automatic flit_t make_response(input tile_t src, input packet_id_t id);
    flit_t f;
    f = '0;
    f[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB]     = `DMA_FLIT_SINGLE;
    f[`DMA_DEST_MSB:`DMA_DEST_LSB]               = src;
    f[`DMA_CLASS_MSB:`DMA_CLASS_LSB]             = `DMA_CLASS_DMA;
    f[`DMA_PACKET_ID_MSB:`DMA_PACKET_ID_LSB]     = id;
    f[`DMA_PACKET_TYPE_MSB:`DMA_PACKET_TYPE_LSB] = `DMA_PTYPE_L2R_RESP;
    return f;
  endfunction

  // Starts on a falling edge and returns on the falling edge after the transfer
  task automatic send_flit(input flit_t f);
    noc_in_flit  = f;
    noc_in_valid = 1'b1;
    // Ready only moves on a rising edge
    while (!noc_in_ready) @(negedge clk);
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  // ptype, src, id, req_last, addr, words, stall_mask, resp_stall, exp_resp
  task automatic fill_table();
    rows[0] = '{`DMA_PTYPE_L2R_REQ, 5'd1,  4'd1,  1'b1, 32'h1000_0000, 5'd1,
                16'h0000, 4'd0,  1'b1};
    rows[1] = '{`DMA_PTYPE_L2R_REQ, 5'd2,  4'd2,  1'b0, 32'h2000_0040, 5'd4,
                16'h0000, 4'd0,  1'b0};
    rows[2] = '{`DMA_PTYPE_L2R_REQ, 5'd7,  4'd5,  1'b1, 32'h0000_8000, 5'd14,
                16'h9125, 4'd0,  1'b1};
    rows[3] = '{`DMA_PTYPE_L2R_REQ, 5'd31, 4'd15, 1'b1, 32'h4000_0100, 5'd8,
                16'h0000, 4'd5,  1'b1};
    // Read request in between is dropped silently
    rows[4] = '{`DMA_PTYPE_R2L_REQ, 5'd3,  4'd3,  1'b1, 32'h5000_0000, 5'd6,
                16'h0000, 4'd0,  1'b0};
    rows[5] = '{`DMA_PTYPE_L2R_REQ, 5'd4,  4'd9,  1'b1, 32'h6000_0f00, 5'd14,
                16'hc3a6, 4'd3,  1'b1};
    rows[6] = '{`DMA_PTYPE_L2R_REQ, 5'd9,  4'd10, 1'b0, 32'h7000_0200, 5'd7,
                16'h5555, 4'd0,  1'b0};
    rows[7] = '{`DMA_PTYPE_R2L_REQ, 5'd17, 4'd4,  1'b0, 32'h5000_1000, 5'd3,
                16'h0000, 4'd0,  1'b0};
    rows[8] = '{`DMA_PTYPE_L2R_REQ, 5'd12, 4'd0,  1'b1, 32'h0000_0010, 5'd2,
                16'h0ff0, 4'd9,  1'b1};
    rows[9] = '{`DMA_PTYPE_L2R_REQ, 5'd20, 4'd7,  1'b1, 32'h0800_0000, 5'd12,
                16'ha0a0, 4'd15, 1'b1};
  endtask

  // Sends header, address flit and payload and waits until every expectation is met
  task automatic run_row(input test_row_t row);
    flit_t      f;
    word_t      w;
    bus_write_t bw;
    int         i;
    hready_mask = row.stall_mask;
    resp_stall  = row.resp_stall;
    // Queued before sending so a stray earlier response cannot match
    if (row.exp_resp) begin
      exp_resps.push_back(make_response(row.src, row.id));
    end
    send_flit(make_header(row));
    f = '0;
    f[`DMA_WORD_WIDTH-1:0] = row.addr;
    send_flit(f);
    for (i = 0; i < int'(row.words); i++) begin
      draw_word(w);
      f = '0;
      f[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB] =
        (i == int'(row.words) - 1) ? `DMA_FLIT_LAST : `DMA_FLIT_PAYLOAD;
      f[`DMA_WORD_WIDTH-1:0] = w;
      // Word i lands at start plus 4 times i
      if (row.ptype == `DMA_PTYPE_L2R_REQ) begin
        bw.addr  = row.addr + addr_t'(4 * i);
        bw.data  = w;
        bw.trans = (i == 0) ? `DMA_HTRANS_NONSEQ : `DMA_HTRANS_SEQ;
        exp_writes.push_back(bw);
      end
      send_flit(f);
    end
    noc_in_valid = 1'b0;
    while (exp_writes.size() != 0 || exp_resps.size() != 0) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // AHB slave model sampling one ns before the rising edge
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic       hready_next;
    logic       dp_active;
    addr_t      dp_addr;
    logic [1:0] dp_trans;
    logic       data_held;
    word_t      held_data;
    bus_write_t bw;
    int         cyc;
    hready      = 1'b1;
    hready_next = 1'b1;
    dp_active   = 1'b0;
    data_held   = 1'b0;
    cyc         = 0;
    forever begin
      @(negedge clk);
      hready = hready_next;
      #(HALF_PERIOD - 1);
      if (!rst) begin
        if (dp_active) begin
          // Write data must not move during wait states
          if (data_held) begin
            check_value("hwdata", hwdata, held_data);
          end
          if (hready) begin
            if (exp_writes.size() == 0) begin
              abort_run($sformatf("AHB write to %h with no word pending", dp_addr));
            end else begin
              bw = exp_writes.pop_front();
              check_value("haddr", dp_addr, bw.addr);
              check_value("htrans", dp_trans, bw.trans);
              check_value("hwdata", hwdata, bw.data);
            end
            dp_active = 1'b0;
            data_held = 1'b0;
          end else begin
            data_held = 1'b1;
            held_data = hwdata;
            // No new beat while the data phase waits
            check_value("htrans", htrans, `DMA_HTRANS_IDLE);
          end
        end
        // Address phase taken only with hready high
        if (hready && htrans != `DMA_HTRANS_IDLE) begin
          dp_active = 1'b1;
          dp_addr   = haddr;
          dp_trans  = htrans;
        end
        // Stalls only ever hit a live data phase
        hready_next = !(dp_active && hready_mask[cyc % 16]);
        cyc++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // NoC response sink
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic  ready_next;
    logic  resp_held;
    flit_t held_flit;
    flit_t exp_flit;
    int    wait_cycles;
    noc_out_ready = 1'b0;
    ready_next    = 1'b0;
    resp_held     = 1'b0;
    wait_cycles   = 0;
    forever begin
      @(negedge clk);
      noc_out_ready = ready_next;
      #(HALF_PERIOD - 1);
      if (!rst) begin
        if (noc_out_valid) begin
          // Flit held steady while backpressured
          if (resp_held) begin
            check_value("noc_out_flit", noc_out_flit, held_flit);
          end
          if (noc_out_ready) begin
            if (exp_resps.size() == 0) begin
              abort_run("response flit sent for a packet that asked for none");
            end else begin
              exp_flit = exp_resps.pop_front();
              check_value("noc_out_flit", noc_out_flit, exp_flit);
            end
            resp_held   = 1'b0;
            wait_cycles = 0;
          end else begin
            resp_held   = 1'b1;
            held_flit   = noc_out_flit;
            wait_cycles++;
          end
        end else if (resp_held) begin
          abort_run("noc_out_valid dropped before the response was accepted");
        end
        // Ready comes back after the row's stall count
        ready_next = (wait_cycles >= int'(resp_stall));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int r;
    rst          = 1'b1;
    noc_in_flit  = '0;
    noc_in_valid = 1'b0;
    hready_mask  = '0;
    resp_stall   = '0;
    lfsr_state   = 32'd4;
    fill_table();
    repeat (16) @(negedge clk);
    rst = 1'b0;
    // Reset values still showing
    check_value("noc_out_valid", noc_out_valid, 1'b0);
    check_value("htrans", htrans, `DMA_HTRANS_IDLE);
    check_value("noc_in_ready", noc_in_ready, 1'b1);
    for (r = 0; r < NUM_ROWS; r++) begin
      run_row(rows[r]);
    end
    // Room for a stray write or response to appear
    repeat (40) @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

  initial begin
    int total_words;
    int r;
    total_words = 0;
    @(negedge clk);
    for (r = 0; r < NUM_ROWS; r++) begin
      total_words += int'(rows[r].words);
    end
    repeat (total_words * CYCLES_PER_WORD + WATCH_MARGIN) @(posedge clk);
    abort_run("timeout: the DUT stopped making progress before all packets were served");
  end

endmodule
